/* rtl/graph_consts.svh */
////////////////////////////////////////////////////////////
// widths, peer count and result queue sizing for the
// graph sum-kernel array; include where a size is needed
////////////////////////////////////////////////////////////

`ifndef GRAPH_CONSTS_SVH
`define GRAPH_CONSTS_SVH

// vertex job fields
`define GRAPH_VERTEX_BITS 16
`define GRAPH_DEGREE_BITS 16

// edge value, also the width of a sum
`define GRAPH_VALUE_BITS 32

// peers sharing the write port
`define GRAPH_NUM_KERNELS 2
`define GRAPH_KERNEL_ID_BITS 1

// per-peer result queue, almost-full leaves two slots spare
`define GRAPH_RESULT_FIFO_DEPTH 8
`define GRAPH_RESULT_FIFO_ALFULL 6

`endif

/* rtl/graph_job_pkg.sv */
////////////////////////////////////////////////////////////
// types for incoming work: vertex jobs and edge values
// referenced by scoped name from the kernels and the top
////////////////////////////////////////////////////////////

`default_nettype none

`include "graph_consts.svh"

package graph_job_pkg;

	// meaningful widths
	typedef logic [`GRAPH_VERTEX_BITS-1:0] vertex_id_t;
	typedef logic [`GRAPH_DEGREE_BITS-1:0] degree_t;
	typedef logic [`GRAPH_VALUE_BITS-1:0]  edge_value_t;

	// one job per vertex, valid is a single-cycle strobe
	typedef struct packed {
		logic       valid;
		vertex_id_t index;
		degree_t    degree;
	} vertex_job_t;

	// one edge value per strobe
	typedef struct packed {
		logic        valid;
		edge_value_t value;
	} edge_data_t;

endpackage

`default_nettype wire

/* rtl/graph_bus_pkg.sv */
////////////////////////////////////////////////////////////
// types for the shared write side: result lines, the
// registered write strobe and result queue status
////////////////////////////////////////////////////////////

`default_nettype none

`include "graph_consts.svh"

package graph_bus_pkg;

	typedef logic [`GRAPH_KERNEL_ID_BITS-1:0] kernel_id_t;

	// finished vertex as it leaves a peer
	typedef struct packed {
		graph_job_pkg::vertex_id_t  index;
		kernel_id_t                 kernel_id;
		graph_job_pkg::edge_value_t sum;
	} result_line_t;

	typedef struct packed {
		logic         valid;
		result_line_t line;
	} result_write_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
	} fifo_status_t;

endpackage

`default_nettype wire

/* rtl/result_fifo.sv */
////////////////////////////////////////////////////////////
// synchronous result queue for one peer
// head entry is always on data_out, pop advances it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "graph_consts.svh"

module result_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  wire logic                 clock,
	input  wire logic                 rstn,
	input  wire logic                 push,
	input  wire logic [WIDTH-1:0]     data_in,
	input  wire logic                 pop,
	output logic [WIDTH-1:0]          data_out,
	output graph_bus_pkg::fifo_status_t status
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	assign status.full   = (count == CNT_BITS'(DEPTH));
	assign status.alfull = (count >= CNT_BITS'(`GRAPH_RESULT_FIFO_ALFULL));
	assign status.empty  = (count == '0);

	assign data_out = mem[rd_ptr];

	// storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap at DEPTH, not at a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) push |-> !status.full)
		else $error("result_fifo: push while full, line dropped");

	assert property (@(posedge clock) disable iff (!rstn) pop |-> !status.empty)
		else $error("result_fifo: pop while empty");

endmodule

`default_nettype wire

/* rtl/sum_kernel.sv */
////////////////////////////////////////////////////////////
// one sum-kernel peer: takes a vertex job, adds up its
// edge values and queues {index, kernel id, sum} lines
// for the shared write port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "graph_consts.svh"

module sum_kernel #(
	parameter int KERNEL_ID = 0
) (
	input  wire logic                        clock,
	input  wire logic                        rstn,
	input  wire graph_job_pkg::vertex_job_t  vertex_job,
	input  wire graph_job_pkg::edge_data_t   edge_data,
	output logic                             edge_ready,
	output logic                             job_busy,
	output logic                             write_request,
	output graph_bus_pkg::result_line_t      write_line,
	input  wire logic                        write_grant
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCUM,
		ST_RETIRE
	} kernel_state_t;

	kernel_state_t                state;
	graph_job_pkg::vertex_id_t    job_index;
	graph_job_pkg::degree_t       job_degree;
	graph_job_pkg::degree_t       edge_count;
	graph_job_pkg::degree_t       edge_count_next;
	graph_job_pkg::edge_value_t   sum;
	graph_bus_pkg::result_line_t  line_in;
	graph_bus_pkg::fifo_status_t  fifo_status;
	logic                         line_push;

////////////////////////////////////////////////////////////
// job state machine
////////////////////////////////////////////////////////////

	assign edge_count_next = edge_count + 1'b1;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= ST_IDLE;
			edge_count <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (vertex_job.valid) begin
						state      <= ST_ACCUM;
						edge_count <= '0;
					end
				end
				ST_ACCUM: begin
					if (edge_data.valid) begin
						edge_count <= edge_count_next;
						// last edge of the job
						if (edge_count_next == job_degree) begin
							state <= ST_RETIRE;
						end
					end
				end
				ST_RETIRE: begin
					state      <= ST_IDLE;
					edge_count <= '0;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// job fields and running sum, wrapping at 2^32
	always_ff @(posedge clock) begin
		if (state == ST_IDLE && vertex_job.valid) begin
			job_index  <= vertex_job.index;
			job_degree <= vertex_job.degree;
			sum        <= '0;
		end else if (state == ST_ACCUM && edge_data.valid) begin
			sum <= sum + edge_data.value;
		end else if (state == ST_RETIRE) begin
			sum <= '0;
		end
	end

	assign job_busy   = (state != ST_IDLE);
	assign edge_ready = (state == ST_ACCUM) && !fifo_status.alfull;

////////////////////////////////////////////////////////////
// result queue
////////////////////////////////////////////////////////////

	assign line_push         = (state == ST_RETIRE);
	assign line_in.index     = job_index;
	assign line_in.kernel_id = graph_bus_pkg::kernel_id_t'(KERNEL_ID);
	assign line_in.sum       = sum;

	result_fifo #(
		.WIDTH($bits(graph_bus_pkg::result_line_t)),
		.DEPTH(`GRAPH_RESULT_FIFO_DEPTH)
	) u_result_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (line_push),
		.data_in (line_in),
		.pop     (write_grant),
		.data_out(write_line),
		.status  (fifo_status)
	);

	// head of queue asks for the port, grant pops it
	assign write_request = !fifo_status.empty;

	assert property (@(posedge clock) disable iff (!rstn) vertex_job.valid |-> !job_busy)
		else $error("sum_kernel %0d: job strobe while busy", KERNEL_ID);

	assert property (@(posedge clock) disable iff (!rstn)
		edge_data.valid |-> state == ST_ACCUM)
		else $error("sum_kernel %0d: edge strobe outside accumulation", KERNEL_ID);

	assert property (@(posedge clock) disable iff (!rstn)
		vertex_job.valid |-> vertex_job.degree != '0)
		else $error("sum_kernel %0d: job with zero degree", KERNEL_ID);

endmodule

`default_nettype wire

/* rtl/write_port_arbiter.sv */
////////////////////////////////////////////////////////////
// round-robin owner of the shared write port
// grants one requesting peer per cycle and registers its
// line onto result_write one cycle later
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "graph_consts.svh"

module write_port_arbiter (
	input  wire logic                          clock,
	input  wire logic                          rstn,
	input  wire logic [`GRAPH_NUM_KERNELS-1:0] write_request,
	input  wire graph_bus_pkg::result_line_t   write_line [`GRAPH_NUM_KERNELS],
	output logic [`GRAPH_NUM_KERNELS-1:0]      write_grant,
	output graph_bus_pkg::result_write_t       result_write
);

	graph_bus_pkg::kernel_id_t    last_id;
	graph_bus_pkg::kernel_id_t    grant_id;
	logic                         grant_any;
	logic                         out_valid;
	graph_bus_pkg::result_line_t  out_line;

	// search starts one past the last granted peer
	always_comb begin : rr_select
		int slot;
		write_grant = '0;
		grant_id    = last_id;
		grant_any   = 1'b0;
		for (int offset = 1; offset <= `GRAPH_NUM_KERNELS; offset++) begin
			slot = (int'(last_id) + offset) % `GRAPH_NUM_KERNELS;
			if (!grant_any && write_request[slot]) begin
				grant_any         = 1'b1;
				grant_id          = graph_bus_pkg::kernel_id_t'(slot);
				write_grant[slot] = 1'b1;
			end
		end
	end

	// peer 0 wins the first contest after reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_id   <= graph_bus_pkg::kernel_id_t'(`GRAPH_NUM_KERNELS - 1);
			out_valid <= 1'b0;
		end else begin
			out_valid <= grant_any;
			if (grant_any) begin
				last_id <= grant_id;
			end
		end
	end

	always_ff @(posedge clock) begin
		out_line <= write_line[grant_id];
	end

	assign result_write.valid = out_valid;
	assign result_write.line  = out_line;

	assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(write_grant) && ((write_grant & ~write_request) == '0))
		else $error("write_port_arbiter: grant not one-hot or not to a requester");

endmodule

`default_nettype wire

/* rtl/sum_array_top.sv */
////////////////////////////////////////////////////////////
// graph sum array slice: sum-kernel peers sharing one
// write port through the round-robin arbiter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "graph_consts.svh"

module sum_array_top (
	input  wire logic                        clock,
	input  wire logic                        rstn,
	input  wire graph_job_pkg::vertex_job_t  vertex_job [`GRAPH_NUM_KERNELS],
	input  wire graph_job_pkg::edge_data_t   edge_data [`GRAPH_NUM_KERNELS],
	output logic [`GRAPH_NUM_KERNELS-1:0]    edge_ready,
	output logic [`GRAPH_NUM_KERNELS-1:0]    job_busy,
	output graph_bus_pkg::result_write_t     result_write
);

	logic [`GRAPH_NUM_KERNELS-1:0] write_request;
	logic [`GRAPH_NUM_KERNELS-1:0] write_grant;
	graph_bus_pkg::result_line_t   write_line [`GRAPH_NUM_KERNELS];

	// one peer per kernel id
	for (genvar k = 0; k < `GRAPH_NUM_KERNELS; k++) begin : gen_kernel
		sum_kernel #(
			.KERNEL_ID(k)
		) u_sum_kernel (
			.clock        (clock),
			.rstn         (rstn),
			.vertex_job   (vertex_job[k]),
			.edge_data    (edge_data[k]),
			.edge_ready   (edge_ready[k]),
			.job_busy     (job_busy[k]),
			.write_request(write_request[k]),
			.write_line   (write_line[k]),
			.write_grant  (write_grant[k])
		);
	end

	write_port_arbiter u_write_port_arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.write_request(write_request),
		.write_line   (write_line),
		.write_grant  (write_grant),
		.result_write (result_write)
	);

endmodule

`default_nettype wire

/* verification/sum_array_checker.sv */
////////////////////////////////////////////////////////////
// result checker for the sum array: keeps expected lines
// per peer, compares each write strobe and the peer status
// outputs, and counts errors
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "graph_consts.svh"

module sum_array_checker (
	input wire logic                          clock,
	input wire logic                          rstn,
	input wire logic [`GRAPH_NUM_KERNELS-1:0] edge_ready,
	input wire logic [`GRAPH_NUM_KERNELS-1:0] job_busy,
	input wire graph_bus_pkg::result_write_t  result_write
);

	graph_bus_pkg::result_line_t expected_lines [`GRAPH_NUM_KERNELS][$];
	string                       expected_tests [`GRAPH_NUM_KERNELS][$];
	int                          compared   = 0;
	int                          mismatches = 0;
	int                          unexpected = 0;

	// plain sum of the edge values, reduced modulo 2^32
	function automatic graph_bus_pkg::result_line_t reference_line(
		input graph_job_pkg::vertex_id_t  index,
		input int                         peer,
		input graph_job_pkg::edge_value_t values [$]
	);
		graph_bus_pkg::result_line_t line;
		longint unsigned             total;
		total = 0;
		foreach (values[i]) begin
			total += values[i];
		end
		line.index     = index;
		line.kernel_id = graph_bus_pkg::kernel_id_t'(peer);
		line.sum       = graph_job_pkg::edge_value_t'(total % 64'h1_0000_0000);
		return line;
	endfunction

	task automatic expect_line(
		input string                      test,
		input int                         peer,
		input graph_job_pkg::vertex_id_t  index,
		input graph_job_pkg::edge_value_t values [$]
	);
		expected_lines[peer].push_back(reference_line(index, peer, values));
		expected_tests[peer].push_back(test);
	endtask

	// job_busy of one peer against the level the job flow implies
	task automatic check_busy(
		input string test,
		input int    peer,
		input logic  busy
	);
		if (job_busy[peer] !== busy) begin
			mismatches++;
			$display("** Error %s: expected job_busy[%0d] %b, actual %b",
				test, peer, busy, job_busy[peer]);
		end
	endtask

	function automatic int pending_lines();
		int total;
		total = 0;
		for (int k = 0; k < `GRAPH_NUM_KERNELS; k++) begin
			total += expected_lines[k].size();
		end
		return total;
	endfunction

	function automatic int error_total();
		return mismatches + unexpected + pending_lines();
	endfunction

	task automatic print_summary();
		$display("checker: %0d compared, %0d mismatches, %0d unexpected writes, %0d missing",
			compared, mismatches, unexpected, pending_lines());
	endtask

	// edge_ready is only high while a job accumulates
	always @(negedge clock) begin : compare_ready
		for (int k = 0; k < `GRAPH_NUM_KERNELS; k++) begin
			if (rstn && edge_ready[k] && !job_busy[k]) begin
				mismatches++;
				$display("edge_ready of kernel %0d high at %0t while the peer is idle",
					k, $time);
			end
		end
	end

	// result_write is registered, so the value seen here is settled
	always @(posedge clock) begin : compare_writes
		graph_bus_pkg::result_line_t want;
		graph_bus_pkg::result_line_t got;
		string                       test;
		int                          peer;
		if (rstn && result_write.valid) begin
			got  = result_write.line;
			peer = int'(got.kernel_id);
			if (expected_lines[peer].size() == 0) begin
				unexpected++;
				$display("unexpected write at %0t: vertex %h from kernel %0d with no job pending",
					$time, got.index, peer);
			end else begin
				want = expected_lines[peer].pop_front();
				test = expected_tests[peer].pop_front();
				compared++;
				if (got !== want) begin
					mismatches++;
					$display("** Error %s: expected index %h id %0d sum %h, actual index %h id %0d sum %h",
						test, want.index, want.kernel_id, want.sum,
						got.index, got.kernel_id, got.sum);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/sum_array_tb.sv */
////////////////////////////////////////////////////////////
// testbench for the graph sum array: clock, reset, random
// vertex jobs per peer and a watchdog
// results are compared in sum_array_checker
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "graph_consts.svh"

module sum_array_tb;

	localparam int RANDOM_JOBS = 12;
	localparam int BURST_JOBS  = 20;
	localparam int MAX_DEGREE  = 40;
	// longest possible run, sizes the watchdog
	localparam int NUM_JOBS  = 1 + 2 * RANDOM_JOBS + 1 + 2 + BURST_JOBS;
	localparam int MAX_EDGES = 1 + 2 * RANDOM_JOBS * MAX_DEGREE + 16 + 2 * 5 + BURST_JOBS * 2;

	logic                          clock;
	logic                          rstn;
	graph_job_pkg::vertex_job_t    vertex_job [`GRAPH_NUM_KERNELS];
	graph_job_pkg::edge_data_t     edge_data [`GRAPH_NUM_KERNELS];
	logic [`GRAPH_NUM_KERNELS-1:0] edge_ready;
	logic [`GRAPH_NUM_KERNELS-1:0] job_busy;
	graph_bus_pkg::result_write_t  result_write;
	logic [31:0]                   lfsr_state = 32'hc7f7_b0bb;
	graph_job_pkg::vertex_id_t     next_index = 16'h0100;

	sum_array_top uut (
		.clock       (clock),
		.rstn        (rstn),
		.vertex_job  (vertex_job),
		.edge_data   (edge_data),
		.edge_ready  (edge_ready),
		.job_busy    (job_busy),
		.result_write(result_write)
	);

	sum_array_checker u_sum_array_checker (
		.clock       (clock),
		.rstn        (rstn),
		.edge_ready  (edge_ready),
		.job_busy    (job_busy),
		.result_write(result_write)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////

	task automatic send_job(input int k, input string test, input int degree, input bit near_top);
		graph_job_pkg::edge_value_t values [$];
		graph_job_pkg::vertex_id_t  index;
		logic [31:0]                draw;
		int                         sent;
		index = next_index;
		next_index++;
		for (int e = 0; e < degree; e++) begin
			if (near_top) begin
				draw = random_bits(4);
				values.push_back({28'hfff_ffff, draw[3:0]});
			end else begin
				values.push_back(random_bits(32));
			end
		end
		u_sum_array_checker.expect_line(test, k, index, values);
		while (job_busy[k]) begin
			@(negedge clock);
		end
		vertex_job[k].valid  = 1'b1;
		vertex_job[k].index  = index;
		vertex_job[k].degree = graph_job_pkg::degree_t'(degree);
		@(negedge clock);
		vertex_job[k] = '0;
		u_sum_array_checker.check_busy(test, k, 1'b1);
		sent = 0;
		// hold off while the peer's queue is nearly full
		while (sent < degree) begin
			edge_data[k].valid = edge_ready[k];
			edge_data[k].value = values[sent];
			if (edge_ready[k]) begin
				sent++;
			end
			@(negedge clock);
		end
		edge_data[k] = '0;
	endtask

	task automatic run_jobs(input int k, input string test, input int jobs,
		input int min_degree, input int span, input bit near_top);
		for (int j = 0; j < jobs; j++) begin
			send_job(k, test, min_degree + int'(random_bits(6)) % span, near_top);
		end
	endtask

	task automatic wait_for_drain();
		while (u_sum_array_checker.pending_lines() != 0 || job_busy != '0) begin
			@(negedge clock);
		end
		// room for a late or duplicated strobe
		repeat (8) @(negedge clock);
	endtask

	initial begin : main_flow
		rstn = 1'b0;
		for (int k = 0; k < `GRAPH_NUM_KERNELS; k++) begin
			vertex_job[k] = '0;
			edge_data[k]  = '0;
		end
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		// idle after reset, any write here counts as unexpected
		repeat (20) @(negedge clock);
		for (int k = 0; k < `GRAPH_NUM_KERNELS; k++) begin
			u_sum_array_checker.check_busy("reset_idle", k, 1'b0);
		end
		run_jobs(0, "single_edge", 1, 1, 1, 1'b0);
		wait_for_drain();
		fork
			run_jobs(0, "random_jobs", RANDOM_JOBS, 1, MAX_DEGREE, 1'b0);
			run_jobs(1, "random_jobs", RANDOM_JOBS, 1, MAX_DEGREE, 1'b0);
		join
		wait_for_drain();
		run_jobs(1, "overflow", 1, 16, 1, 1'b1);
		wait_for_drain();
		// same degree on both peers, so both retire in the same cycle
		fork
			run_jobs(0, "contention", 1, 5, 1, 1'b0);
			run_jobs(1, "contention", 1, 5, 1, 1'b0);
		join
		wait_for_drain();
		run_jobs(0, "back_to_back", BURST_JOBS, 1, 2, 1'b0);
		wait_for_drain();
		u_sum_array_checker.print_summary();
		if (u_sum_array_checker.error_total() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (MAX_EDGES * 4 + NUM_JOBS * 20 + 200) @(posedge clock);
		$display("watchdog: run did not finish in time, a peer or the write port hung");
		u_sum_array_checker.print_summary();
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/graph_job_pkg.sv
rtl/graph_bus_pkg.sv
rtl/result_fifo.sv
rtl/sum_kernel.sv
rtl/write_port_arbiter.sv
rtl/sum_array_top.sv
verification/sum_array_checker.sv
verification/sum_array_tb.sv

/* Bender.yml */
package:
  name: graph_sum_array

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/graph_job_pkg.sv
      - rtl/graph_bus_pkg.sv
      - rtl/result_fifo.sv
      - rtl/sum_kernel.sv
      - rtl/write_port_arbiter.sv
      - rtl/sum_array_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/sum_array_checker.sv
      - verification/sum_array_tb.sv
